//--- src.f
rtl/gfx_pixel_pkg.sv
rtl/gfx_rop_pkg.sv
rtl/gfx_color_split.sv
rtl/gfx_rop_exec.sv
rtl/gfx_color_pack.sv
rtl/gfx_pixel_op.sv
testbench/gfx_pixel_op_asserts.sv
testbench/gfx_pixel_op_tb.sv

//--- Makefile
# Verilator build and run of the pixel operation unit testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= gfx_pixel_op_tb
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# build, run, then decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/gfx_pixel_op_tb.sv
// ================================================
// directed tests for the pixel operation unit
// inputs change on the falling edge, outputs sampled there too
// expected words come from a reference model of split, op, pack
// results are paired with their strobes through a queue
// ================================================
`timescale 1ns/100ps
`default_nettype none

module gfx_pixel_op_tb
  import gfx_pixel_pkg::*, gfx_rop_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int COPY_PIXELS = 8 * 4;
  localparam int LOGIC_PIXELS = 8 * 5 * 2;
  localparam int BLEND_PIXELS = 4 * 5 + 2 * 2;
  localparam int STREAM_PIXELS = 64;
  localparam int TOTAL_PIXELS = 1 + COPY_PIXELS + LOGIC_PIXELS + BLEND_PIXELS + STREAM_PIXELS;
  localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * 4 + 200;

  logic   clk_i = 1'b0;
  logic   reset_i;
  logic   valid_i;
  depth_t depth_i;
  rop_t   op_i;
  alpha_t alpha_i;
  pixel_t src_i;
  pixel_t dst_i;
  logic   valid_o;
  pixel_t pixel_o;

  int     seed = 32'hd43d;
  int     cycle_count = 0;
  // expected word and the cycle count at which it must show
  pixel_t exp_pixel_q[$];
  int     exp_cycle_q[$];

  gfx_pixel_op gfx_pixel_op_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .depth_i (depth_i),
    .op_i    (op_i),
    .alpha_i (alpha_i),
    .src_i   (src_i),
    .dst_i   (dst_i),
    .valid_o (valid_o),
    .pixel_o (pixel_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) cycle_count <= cycle_count + 1;

  // ================================================
  // checking and reference model
  // ================================================

  task automatic check_value(input pixel_t got, input pixel_t expected, input string what);
    if (got !== expected) begin
      $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, what, got, expected);
      $display("Test failures found");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic abort_run(input string why);
    $display("ERROR at %0t ns: %s", $time, why);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  // index 0 is blue at bit 0, green above it, red on top
  function automatic pixel_t ref_pixel(input depth_t d, input rop_t op, input alpha_t a,
                                       input pixel_t src, input pixel_t dst);
    int     w[3];
    int     sh[3];
    pixel_t m;
    pixel_t s;
    pixel_t t;
    pixel_t r;
    pixel_t res;
    case (d)
      // indexed depths keep the index alone in the red slot
      3'd0: w = '{0, 0, 1};
      3'd1: w = '{0, 0, 8};
      3'd2: w = '{4, 4, 4};
      3'd3: w = '{5, 6, 5};
      3'd4: w = '{8, 9, 8};
      default: w = '{10, 11, 11};
    endcase
    sh = '{0, w[0], w[0] + w[1]};
    res = '0;
    for (int i = 0; i < 3; i++) begin
      m = (32'd1 << w[i]) - 32'd1;
      s = (src >> sh[i]) & m;
      t = (dst >> sh[i]) & m;
      case (op)
        ROP_AND:     r = s & t;
        ROP_OR:      r = s | t;
        ROP_XOR:     r = s ^ t;
        ROP_INV_DST: r = ~t;
        ROP_CLEAR:   r = '0;
        ROP_BLEND: begin
          if (d < DEPTH_BPP12) begin
            r = s;
          end else begin
            r = (s * {24'd0, a} + t * (32'd256 - {24'd0, a})) >> 8;
          end
        end
        default:     r = s;
      endcase
      res = res | ((r & m) << sh[i]);
    end
    return res;
  endfunction

  function automatic pixel_t rand_word();
    return $random(seed);
  endfunction

  // ================================================
  // stimulus helpers
  // ================================================

  task automatic send_pixel(input depth_t d, input rop_t op, input alpha_t a,
                            input pixel_t src, input pixel_t dst, input pixel_t expected);
    @(negedge clk_i);
    valid_i = 1'b1;
    depth_i = d;
    op_i    = op;
    alpha_i = a;
    src_i   = src;
    dst_i   = dst;
    // valid_o rises on the third rising edge from here
    exp_pixel_q.push_back(expected);
    exp_cycle_q.push_back(cycle_count + 3);
  endtask

  task automatic idle_input();
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_pixel_q.size() != 0) @(posedge clk_i);
  endtask

  task automatic run_single(input depth_t d, input rop_t op, input alpha_t a,
                            input pixel_t src, input pixel_t dst, input pixel_t expected);
    send_pixel(d, op, a, src, dst, expected);
    idle_input();
    wait_drained();
  endtask

  // ================================================
  // result monitor
  // ================================================
  always @(negedge clk_i) begin
    if (reset_i === 1'b0 && valid_o === 1'b1) begin
      if (exp_pixel_q.size() == 0) begin
        abort_run("valid_o was asserted with no pixel in flight");
      end else begin
        check_value(cycle_count, exp_cycle_q.pop_front(), "result latency in cycles");
        check_value(pixel_o, exp_pixel_q.pop_front(), "pixel_o");
      end
    end else if (reset_i === 1'b0 && exp_cycle_q.size() != 0) begin
      if (exp_cycle_q[0] <= cycle_count) begin
        abort_run("an expected result never appeared on valid_o");
      end
    end
  end

  // ================================================
  // tests
  // ================================================

  task automatic test_reset_latency();
    repeat (10) begin
      @(negedge clk_i);
      check_value({31'd0, valid_o}, 32'd0, "valid_o idle after reset");
    end
    run_single(DEPTH_BPP16, ROP_COPY, 8'd0, 32'h0000_a5c3, 32'h0, 32'h0000_a5c3);
    // the strobe must not repeat
    repeat (4) begin
      @(negedge clk_i);
      check_value({31'd0, valid_o}, 32'd0, "valid_o strobes once per pixel");
    end
  endtask

  // every code including the spare ones, unused bits must clear
  task automatic test_copy();
    pixel_t src;
    pixel_t dst;
    for (int d = 0; d < 8; d++) begin
      for (int k = 0; k < COPY_PIXELS / 8; k++) begin
        src = rand_word();
        dst = rand_word();
        run_single(depth_t'(d), ROP_COPY, 8'd0, src, dst,
                   ref_pixel(depth_t'(d), ROP_COPY, 8'd0, src, dst));
      end
    end
  endtask

  task automatic test_logic_ops();
    rop_t   ops[5] = '{ROP_AND, ROP_OR, ROP_XOR, ROP_INV_DST, ROP_CLEAR};
    pixel_t src;
    pixel_t dst;
    for (int d = 0; d < 8; d++) begin
      for (int o = 0; o < 5; o++) begin
        repeat (LOGIC_PIXELS / 40) begin
          src = rand_word();
          dst = rand_word();
          run_single(depth_t'(d), ops[o], 8'd0, src, dst,
                     ref_pixel(depth_t'(d), ops[o], 8'd0, src, dst));
        end
      end
    end
  endtask

  task automatic test_blend();
    pixel_t src;
    pixel_t dst;
    pixel_t rnd;
    alpha_t a;
    for (int d = 2; d < 6; d++) begin
      for (int k = 0; k < 5; k++) begin
        src = rand_word();
        dst = rand_word();
        rnd = rand_word();
        a = (k == 0) ? 8'd0 : (k == 1) ? 8'd128 : rnd[7:0];
        if (a == 8'd0) begin
          // zero source weight must hand back dst unchanged
          run_single(depth_t'(d), ROP_BLEND, a, src, dst,
                     ref_pixel(depth_t'(d), ROP_COPY, a, dst, src));
        end else begin
          run_single(depth_t'(d), ROP_BLEND, a, src, dst,
                     ref_pixel(depth_t'(d), ROP_BLEND, a, src, dst));
        end
      end
    end
    // palette indices do not mix, source wins
    for (int d = 0; d < 2; d++) begin
      repeat (2) begin
        src = rand_word();
        dst = rand_word();
        run_single(depth_t'(d), ROP_BLEND, 8'd77, src, dst,
                   ref_pixel(depth_t'(d), ROP_COPY, 8'd77, src, dst));
      end
    end
  endtask

  // one pixel per cycle, order and spacing checked by the monitor
  task automatic test_streaming();
    pixel_t src;
    pixel_t dst;
    pixel_t ctl;
    for (int i = 0; i < STREAM_PIXELS; i++) begin
      src = rand_word();
      dst = rand_word();
      ctl = rand_word();
      send_pixel(ctl[2:0], ctl[6:4], ctl[15:8], src, dst,
                 ref_pixel(ctl[2:0], ctl[6:4], ctl[15:8], src, dst));
    end
    idle_input();
    wait_drained();
  endtask

  // ================================================
  // sequence and watchdog
  // ================================================
  initial begin
    reset_i = 1'b1;
    valid_i = 1'b0;
    depth_i = '0;
    op_i    = '0;
    alpha_i = '0;
    src_i   = '0;
    dst_i   = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    test_reset_latency();
    test_copy();
    test_logic_ops();
    test_blend();
    test_streaming();
    repeat (4) @(negedge clk_i);
    if (gfx_pixel_op_inst.gfx_pixel_op_asserts_inst.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1, "assertion failures during the run");
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("timeout, the tests did not finish within the time limit");
  end

endmodule

`default_nettype wire

//--- testbench/gfx_pixel_op_asserts.sv
// ================================================
// timing and reset properties of the pixel unit
// bound into every gfx_pixel_op instance
// checks start once three clock edges have passed
// ================================================
`timescale 1ns/100ps
`default_nettype none

module gfx_pixel_op_asserts
  import gfx_pixel_pkg::*;
(
  input wire logic   clk_i,
  input wire logic   reset_i,
  input wire logic   valid_i,
  input wire depth_t depth_i,
  input wire logic   valid_o,
  input wire pixel_t pixel_o
);

  // edges seen so far, saturates so $past has history
  logic [1:0] seen = 2'd0;
  int         latency_errs = 0;
  int         reset_errs = 0;
  int         span_errs = 0;
  int         fail_count;

  assign fail_count = latency_errs + reset_errs + span_errs;

  always @(posedge clk_i) begin
    if (seen != 2'd3) begin
      seen <= seen + 2'd1;
    end
  end

  // fixed 3-cycle latency when no reset hit the pipeline
  latency_a: assert property (@(posedge clk_i)
    (seen == 2'd3) && !$past(reset_i) && !$past(reset_i, 2) && !$past(reset_i, 3)
    |-> valid_o == $past(valid_i, 3))
    else begin
      $error("valid_o does not follow valid_i by 3 cycles");
      latency_errs++;
    end

  // low while in reset and in the first cycle after it
  reset_a: assert property (@(posedge clk_i)
    (seen >= 2'd2) && ($past(reset_i) || $past(reset_i, 2)) |-> !valid_o)
    else begin
      $error("valid_o high during or right after reset");
      reset_errs++;
    end

  // nothing above the 12-bit or 16-bit field span
  span_a: assert property (@(posedge clk_i)
    (seen == 2'd3) && valid_o
    |-> !($past(depth_i, 3) == DEPTH_BPP12 && pixel_o[31:12] != '0)
        && !($past(depth_i, 3) == DEPTH_BPP16 && pixel_o[31:16] != '0))
    else begin
      $error("pixel_o has bits set above the depth's field span");
      span_errs++;
    end

endmodule

bind gfx_pixel_op gfx_pixel_op_asserts gfx_pixel_op_asserts_inst (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .valid_i (valid_i),
  .depth_i (depth_i),
  .valid_o (valid_o),
  .pixel_o (pixel_o)
);

`default_nettype wire

//--- rtl/gfx_pixel_op.sv
// ================================================
// pixel operation unit, three-stage pipeline
// fixed latency of 3 cycles, one pixel per cycle
// no flow control, valid_o lasts one cycle
// ================================================
`timescale 1ns/100ps
`default_nettype none

module gfx_pixel_op
  import gfx_pixel_pkg::*, gfx_rop_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   reset_i,
  input  wire logic   valid_i,
  input  wire depth_t depth_i,
  input  wire rop_t   op_i,
  input  wire alpha_t alpha_i,
  input  wire pixel_t src_i,
  input  wire pixel_t dst_i,
  output logic        valid_o,
  output pixel_t      pixel_o
);

  // ================================================
  // decode to execute
  // ================================================
  logic   dec_valid;
  rop_t   dec_op;
  alpha_t dec_alpha;
  depth_t dec_depth;
  logic   dec_indexed;
  chan_t  dec_src_r, dec_src_g, dec_src_b;
  chan_t  dec_dst_r, dec_dst_g, dec_dst_b;

  // ================================================
  // execute to result
  // ================================================
  logic   exe_valid;
  depth_t exe_depth;
  chan_t  exe_r, exe_g, exe_b;

  // split both operands into channels
  gfx_color_split gfx_color_split_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .valid_i   (valid_i),
    .depth_i   (depth_i),
    .op_i      (op_i),
    .alpha_i   (alpha_i),
    .src_i     (src_i),
    .dst_i     (dst_i),
    .valid_o   (dec_valid),
    .depth_o   (dec_depth),
    .op_o      (dec_op),
    .alpha_o   (dec_alpha),
    .indexed_o (dec_indexed),
    .src_r_o   (dec_src_r),
    .src_g_o   (dec_src_g),
    .src_b_o   (dec_src_b),
    .dst_r_o   (dec_dst_r),
    .dst_g_o   (dec_dst_g),
    .dst_b_o   (dec_dst_b)
  );

  // raster operation per channel
  gfx_rop_exec gfx_rop_exec_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .valid_i   (dec_valid),
    .depth_i   (dec_depth),
    .op_i      (dec_op),
    .alpha_i   (dec_alpha),
    .indexed_i (dec_indexed),
    .src_r_i   (dec_src_r),
    .src_g_i   (dec_src_g),
    .src_b_i   (dec_src_b),
    .dst_r_i   (dec_dst_r),
    .dst_g_i   (dec_dst_g),
    .dst_b_i   (dec_dst_b),
    .valid_o   (exe_valid),
    .depth_o   (exe_depth),
    .r_o       (exe_r),
    .g_o       (exe_g),
    .b_o       (exe_b)
  );

  // repack to the depth layout
  gfx_color_pack gfx_color_pack_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (exe_valid),
    .depth_i (exe_depth),
    .r_i     (exe_r),
    .g_i     (exe_g),
    .b_i     (exe_b),
    .valid_o (valid_o),
    .pixel_o (pixel_o)
  );

endmodule

`default_nettype wire

//--- rtl/gfx_color_pack.sv
// ================================================
// result stage, one register layer
// trims each channel to its field width and packs it
// bits above the depth's span come out zero
// pixel_o holds its value while valid_o is low
// ================================================
`timescale 1ns/100ps
`default_nettype none

module gfx_color_pack
  import gfx_pixel_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   reset_i,
  input  wire logic   valid_i,
  input  wire depth_t depth_i,
  input  wire chan_t  r_i,
  input  wire chan_t  g_i,
  input  wire chan_t  b_i,
  output logic        valid_o,
  output pixel_t      pixel_o
);

  // trim to the field and move it to its place in the word
  function automatic pixel_t put_field(chan_t c, logic [4:0] sh, chan_t mask);
    pixel_t wide;
    wide = {{(PIXEL_W-CHAN_W){1'b0}}, c & mask};
    return wide << sh;
  endfunction

  // blue always lands at bit 0
  logic [4:0] r_sh, g_sh;
  chan_t      r_mask, g_mask, b_mask;
  pixel_t     packed_word;

  // ================================================
  // field layout, mirror of the split stage
  // ================================================
  always_comb begin
    r_sh = 5'd0;
    g_sh = 5'd0;
    // indexed depths take only red
    g_mask = 11'h000;
    b_mask = 11'h000;
    case (depth_i)
      DEPTH_BPP1:  r_mask = 11'h001;
      DEPTH_BPP8:  r_mask = 11'h0ff;
      DEPTH_BPP12: begin
        r_sh = 5'd8;
        g_sh = 5'd4;
        r_mask = 11'h00f;
        g_mask = 11'h00f;
        b_mask = 11'h00f;
      end
      DEPTH_BPP16: begin
        r_sh = 5'd11;
        g_sh = 5'd5;
        r_mask = 11'h01f;
        g_mask = 11'h03f;
        b_mask = 11'h01f;
      end
      DEPTH_BPP25: begin
        r_sh = 5'd17;
        g_sh = 5'd8;
        r_mask = 11'h0ff;
        g_mask = 11'h1ff;
        b_mask = 11'h0ff;
      end
      default: begin
        // bpp32 and spare codes
        r_sh = 5'd21;
        g_sh = 5'd10;
        r_mask = 11'h7ff;
        g_mask = 11'h7ff;
        b_mask = 11'h3ff;
      end
    endcase
  end

  assign packed_word = put_field(r_i, r_sh, r_mask)
                     | put_field(g_i, g_sh, g_mask)
                     | put_field(b_i, 5'd0, b_mask);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // load only on a valid result so the output holds
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      pixel_o <= packed_word;
    end
  end

endmodule

`default_nettype wire

//--- rtl/gfx_rop_exec.sv
// ================================================
// execute stage, one register layer
// same operation on all three channels
// results are not masked, the pack stage trims them
// blend acts as copy on indexed depths
// ================================================
`timescale 1ns/100ps
`default_nettype none

module gfx_rop_exec
  import gfx_pixel_pkg::*, gfx_rop_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   reset_i,
  input  wire logic   valid_i,
  input  wire depth_t depth_i,
  input  wire rop_t   op_i,
  input  wire alpha_t alpha_i,
  input  wire logic   indexed_i,
  input  wire chan_t  src_r_i,
  input  wire chan_t  src_g_i,
  input  wire chan_t  src_b_i,
  input  wire chan_t  dst_r_i,
  input  wire chan_t  dst_g_i,
  input  wire chan_t  dst_b_i,
  output logic        valid_o,
  output depth_t      depth_o,
  output chan_t       r_o,
  output chan_t       g_o,
  output chan_t       b_o
);

  // ================================================
  // blend weights
  // ================================================

  // destination weight, 256 - alpha, 1 to 256
  logic [8:0] dst_w;

  assign dst_w = 9'd256 - {1'b0, alpha_i};

  // ================================================
  // per-channel operation
  // ================================================

  // weighted sum of one channel, 11 bits times 9 bits
  // worst case 2047 * 256 still fits in 19 bits
  function automatic chan_t blend_chan(chan_t s, chan_t d, alpha_t a, logic [8:0] w);
    logic [18:0] src_prod;
    logic [18:0] dst_prod;
    logic [18:0] sum;
    src_prod = {8'd0, s} * {11'd0, a};
    dst_prod = {8'd0, d} * {10'd0, w};
    sum      = src_prod + dst_prod;
    // divide by 256, alpha 0 gives dst exactly
    return sum[18:8];
  endfunction

  function automatic chan_t rop_chan(rop_t op, logic idx, chan_t s, chan_t d,
                                     alpha_t a, logic [8:0] w);
    chan_t res;
    case (op)
      ROP_COPY:    res = s;
      ROP_AND:     res = s & d;
      ROP_OR:      res = s | d;
      ROP_XOR:     res = s ^ d;
      // upper bits set here are dropped when packing
      ROP_INV_DST: res = ~d;
      ROP_BLEND: begin
        // a palette index has no meaningful mix
        if (idx) begin
          res = s;
        end else begin
          res = blend_chan(s, d, a, w);
        end
      end
      ROP_CLEAR:   res = '0;
      // spare code 7 copies
      default:     res = s;
    endcase
    return res;
  endfunction

  chan_t r_nxt, g_nxt, b_nxt;

  assign r_nxt = rop_chan(op_i, indexed_i, src_r_i, dst_r_i, alpha_i, dst_w);
  assign g_nxt = rop_chan(op_i, indexed_i, src_g_i, dst_g_i, alpha_i, dst_w);
  assign b_nxt = rop_chan(op_i, indexed_i, src_b_i, dst_b_i, alpha_i, dst_w);

  // ================================================
  // stage register
  // ================================================

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // depth travels on so the pack stage knows the layout
  always_ff @(posedge clk_i) begin
    depth_o <= depth_i;
    r_o     <= r_nxt;
    g_o     <= g_nxt;
    b_o     <= b_nxt;
  end

endmodule

`default_nettype wire

//--- rtl/gfx_color_split.sv
// ================================================
// decode stage, one register layer
// splits src and dst into right-aligned r, g, b
// indexed depths carry the index in red, g and b are zero
// only valid_o is reset
// ================================================
`timescale 1ns/100ps
`default_nettype none

module gfx_color_split
  import gfx_pixel_pkg::*, gfx_rop_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   reset_i,
  input  wire logic   valid_i,
  input  wire depth_t depth_i,
  input  wire rop_t   op_i,
  input  wire alpha_t alpha_i,
  input  wire pixel_t src_i,
  input  wire pixel_t dst_i,
  output logic        valid_o,
  output depth_t      depth_o,
  output rop_t        op_o,
  output alpha_t      alpha_o,
  output logic        indexed_o,
  output chan_t       src_r_o,
  output chan_t       src_g_o,
  output chan_t       src_b_o,
  output chan_t       dst_r_o,
  output chan_t       dst_g_o,
  output chan_t       dst_b_o
);

  // shift to the field's low bit, then keep the field bits
  function automatic chan_t get_field(pixel_t pix, logic [4:0] sh, chan_t mask);
    pixel_t shifted;
    shifted = pix >> sh;
    return shifted[CHAN_W-1:0] & mask;
  endfunction

  // field boundaries for the current depth
  // blue always starts at bit 0
  logic [4:0] r_sh, g_sh;
  chan_t      r_mask, g_mask, b_mask;
  logic       indexed;

  // ================================================
  // field layout per depth
  // ================================================
  always_comb begin
    indexed = 1'b0;
    r_sh = 5'd0;
    g_sh = 5'd0;
    case (depth_i)
      DEPTH_BPP1: begin
        indexed = 1'b1;
        r_mask = 11'h001;
        g_mask = 11'h000;
        b_mask = 11'h000;
      end
      DEPTH_BPP8: begin
        indexed = 1'b1;
        r_mask = 11'h0ff;
        g_mask = 11'h000;
        b_mask = 11'h000;
      end
      DEPTH_BPP12: begin
        // 4:4:4
        r_sh = 5'd8;
        g_sh = 5'd4;
        r_mask = 11'h00f;
        g_mask = 11'h00f;
        b_mask = 11'h00f;
      end
      DEPTH_BPP16: begin
        // 5:6:5
        r_sh = 5'd11;
        g_sh = 5'd5;
        r_mask = 11'h01f;
        g_mask = 11'h03f;
        b_mask = 11'h01f;
      end
      DEPTH_BPP25: begin
        // 8:9:8
        r_sh = 5'd17;
        g_sh = 5'd8;
        r_mask = 11'h0ff;
        g_mask = 11'h1ff;
        b_mask = 11'h0ff;
      end
      default: begin
        // bpp32 and the spare codes, 11:11:10
        r_sh = 5'd21;
        g_sh = 5'd10;
        r_mask = 11'h7ff;
        g_mask = 11'h7ff;
        b_mask = 11'h3ff;
      end
    endcase
  end

  // strobe, the only reset flop of this stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // payload, same boundaries for both operands
  always_ff @(posedge clk_i) begin
    depth_o   <= depth_i;
    op_o      <= op_i;
    alpha_o   <= alpha_i;
    indexed_o <= indexed;
    src_r_o   <= get_field(src_i, r_sh, r_mask);
    src_g_o   <= get_field(src_i, g_sh, g_mask);
    src_b_o   <= get_field(src_i, 5'd0, b_mask);
    dst_r_o   <= get_field(dst_i, r_sh, r_mask);
    dst_g_o   <= get_field(dst_i, g_sh, g_mask);
    dst_b_o   <= get_field(dst_i, 5'd0, b_mask);
  end

endmodule

`default_nettype wire

//--- rtl/gfx_rop_pkg.sv
// ================================================
// raster operation codes and blend weight
// code 7 is undefined and executes as copy
// ================================================
`default_nettype none

package gfx_rop_pkg;

  localparam int ROP_W   = 3;
  localparam int ALPHA_W = 8;

  typedef logic [ROP_W-1:0]   rop_t;
  // source weight, destination gets 256 minus this
  typedef logic [ALPHA_W-1:0] alpha_t;

  // ================================================
  // operation codes
  // ================================================

  // result = src
  localparam rop_t ROP_COPY    = 3'd0;
  // bitwise per channel
  localparam rop_t ROP_AND     = 3'd1;
  localparam rop_t ROP_OR      = 3'd2;
  localparam rop_t ROP_XOR     = 3'd3;
  // complement of dst, masked later by the field width
  localparam rop_t ROP_INV_DST = 3'd4;
  // weighted mix, copy for indexed depths
  localparam rop_t ROP_BLEND   = 3'd5;
  // result = 0
  localparam rop_t ROP_CLEAR   = 3'd6;

endpackage

`default_nettype wire

//--- rtl/gfx_pixel_pkg.sv
// ================================================
// pixel word, channel and colour depth types
// every depth uses the same 32-bit word, fields right-aligned
// depth codes 6 and 7 are undefined and decode as bpp32
// ================================================
`default_nettype none

package gfx_pixel_pkg;

  // ================================================
  // widths
  // ================================================

  // packed pixel word, same size at every depth
  localparam int PIXEL_W = 32;
  // widest field is 11 bits, red and green of bpp32
  localparam int CHAN_W  = 11;
  // six depths fit in three bits
  localparam int DEPTH_W = 3;

  typedef logic [PIXEL_W-1:0] pixel_t;
  // one colour channel, right aligned, upper bits zero
  typedef logic [CHAN_W-1:0]  chan_t;
  typedef logic [DEPTH_W-1:0] depth_t;

  // ================================================
  // depth codes
  // ================================================

  // 1-bit index in bit 0
  localparam depth_t DEPTH_BPP1  = 3'd0;
  // 8-bit palette index in [7:0]
  localparam depth_t DEPTH_BPP8  = 3'd1;
  // 4:4:4 in [11:0]
  localparam depth_t DEPTH_BPP12 = 3'd2;
  // 5:6:5 in [15:0]
  localparam depth_t DEPTH_BPP16 = 3'd3;
  // 8:9:8 in [24:0]
  localparam depth_t DEPTH_BPP25 = 3'd4;
  // 11:11:10, whole word
  localparam depth_t DEPTH_BPP32 = 3'd5;

endpackage

`default_nettype wire
